//--- hw/axi_iso_defines.svh
`ifndef AXI_ISO_DEFINES_SVH
`define AXI_ISO_DEFINES_SVH

// Bus widths shared by both ports
`define AXI_ISO_ADDR_W 32
`define AXI_ISO_DATA_W 32
`define AXI_ISO_ID_W 4

// Open transactions allowed per counter before new addresses stall
`define AXI_ISO_NUM_PENDING 4

// Counter width
// Holds every value from zero up to and including the pending limit
`define AXI_ISO_CNT_W 3

`endif

//--- hw/axi_iso_pkg.sv
`include "axi_iso_defines.svh"

package axi_iso_pkg;

  //////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////

  typedef logic [`AXI_ISO_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_ISO_DATA_W-1:0]   data_t;
  // One strobe bit per data byte
  typedef logic [`AXI_ISO_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_ISO_ID_W-1:0]     id_t;
  // Burst length minus one, as on the bus
  typedef logic [7:0]                   len_t;
  typedef logic [1:0]                   resp_t;
  // Count of open transactions
  typedef logic [`AXI_ISO_CNT_W-1:0]    cnt_t;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  //////////////////////////////////////////////////
  // Port bundles
  //////////////////////////////////////////////////

  // Everything driven by the master side of a link
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything driven by the slave side of a link
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_resp_t;

  // Isolation FSM of one address channel
  typedef enum logic [1:0] {
    st_normal,
    st_hold,
    st_drain,
    st_isolate
  } iso_state_e;

endpackage

//--- hw/axi_iso_pending_cnt.sv
`timescale 1ns/1ns
`include "axi_iso_defines.svh"

module axi_iso_pending_cnt (
  input  logic clk_i,
  input  logic rst_n_i,
  // One transaction opened this cycle
  input  logic inc_i,
  // One transaction closed this cycle
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  // Number of transactions currently open
  axi_iso_pkg::cnt_t cnt_q;

  //////////////////////////////////////////////////
  // Up/down count
  //////////////////////////////////////////////////

  // Open and close in the same cycle cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (inc_i && !dec_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////

  // Limit reached, no further address may be issued
  assign full_o = (cnt_q == axi_iso_pkg::cnt_t'(`AXI_ISO_NUM_PENDING));

  // Nothing in flight
  assign empty_o = (cnt_q == '0);

endmodule

//--- hw/axi_iso_chan_ctrl.sv
`timescale 1ns/1ns

module axi_iso_chan_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    isolate_i,
  // Address valid from the slave port
  input  logic                    slv_valid_i,
  // Address ready from the master port
  input  logic                    mst_ready_i,
  // Some counter of this path is at its limit
  input  logic                    full_i,
  // No transaction of this path is open
  input  logic                    empty_i,
  // Connect the address handshake
  output logic                    pass_o,
  // Force the master-side valid high
  output logic                    hold_o,
  // Zero the master-side address
  output logic                    cut_o,
  // Address counted as issued this cycle
  output logic                    issue_o,
  output axi_iso_pkg::iso_state_e state_o
);

  axi_iso_pkg::iso_state_e state_q;
  axi_iso_pkg::iso_state_e state_d;

  // Start isolated until isolate_i has been seen low
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= axi_iso_pkg::st_isolate;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state and channel control
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    pass_o  = 1'b0;
    hold_o  = 1'b0;
    cut_o   = 1'b0;
    issue_o = 1'b0;
    case (state_q)
      axi_iso_pkg::st_normal: begin
        if (full_i) begin
          // Handshake stays cut while at the limit
          if (isolate_i) begin
            state_d = axi_iso_pkg::st_drain;
          end
        end else begin
          pass_o  = 1'b1;
          // Counted once on first offer
          issue_o = slv_valid_i;
          if (slv_valid_i && !mst_ready_i) begin
            // Offered but not taken, keep it valid
            state_d = axi_iso_pkg::st_hold;
          end else if (isolate_i) begin
            state_d = axi_iso_pkg::st_drain;
          end
        end
      end
      axi_iso_pkg::st_hold: begin
        // Valid forced high, ready still connected
        pass_o = 1'b1;
        hold_o = 1'b1;
        if (mst_ready_i) begin
          state_d = isolate_i ? axi_iso_pkg::st_drain : axi_iso_pkg::st_normal;
        end
      end
      axi_iso_pkg::st_drain: begin
        // Block new addresses until all responses are back
        cut_o = 1'b1;
        if (empty_i) begin
          state_d = axi_iso_pkg::st_isolate;
        end
      end
      axi_iso_pkg::st_isolate: begin
        cut_o = 1'b1;
        if (!isolate_i) begin
          state_d = axi_iso_pkg::st_normal;
        end
      end
      default: begin
        state_d = axi_iso_pkg::st_isolate;
      end
    endcase
  end

  assign state_o = state_q;

endmodule

//--- hw/axi_iso_write_path.sv
`timescale 1ns/1ns

module axi_iso_write_path (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  isolate_i,
  // Slave port
  input  axi_iso_pkg::aw_chan_t slv_aw_i,
  input  logic                  slv_aw_valid_i,
  input  axi_iso_pkg::w_chan_t  slv_w_i,
  input  logic                  slv_w_valid_i,
  input  logic                  slv_b_ready_i,
  output logic                  slv_aw_ready_o,
  output logic                  slv_w_ready_o,
  output axi_iso_pkg::b_chan_t  slv_b_o,
  output logic                  slv_b_valid_o,
  // Master port
  output axi_iso_pkg::aw_chan_t mst_aw_o,
  output logic                  mst_aw_valid_o,
  output axi_iso_pkg::w_chan_t  mst_w_o,
  output logic                  mst_w_valid_o,
  output logic                  mst_b_ready_o,
  input  logic                  mst_aw_ready_i,
  input  logic                  mst_w_ready_i,
  input  axi_iso_pkg::b_chan_t  mst_b_i,
  input  logic                  mst_b_valid_i,
  // Write side fully isolated
  output logic                  isolated_o
);

  logic                    pass;
  logic                    hold;
  logic                    cut;
  logic                    issue;
  axi_iso_pkg::iso_state_e state;

  logic                    aw_full;
  logic                    aw_empty;
  logic                    w_full;
  logic                    w_empty;
  logic                    w_block;
  logic                    in_iso;

  //////////////////////////////////////////////////
  // Control and counters
  //////////////////////////////////////////////////

  // Drain ends once every B has come back
  axi_iso_chan_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .isolate_i   (isolate_i),
    .slv_valid_i (slv_aw_valid_i),
    .mst_ready_i (mst_aw_ready_i),
    .full_i      (aw_full | w_full),
    .empty_i     (aw_empty),
    .pass_o      (pass),
    .hold_o      (hold),
    .cut_o       (cut),
    .issue_o     (issue),
    .state_o     (state)
  );

  // Bursts open from AW issue to B handshake
  axi_iso_pending_cnt u_burst_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .inc_i   (issue),
    .dec_i   (mst_b_valid_i & mst_b_ready_o),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  // Data bursts open from AW issue to the last W beat
  axi_iso_pending_cnt u_data_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .inc_i   (issue),
    .dec_i   (mst_w_valid_o & mst_w_ready_i & mst_w_o.last),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  //////////////////////////////////////////////////
  // AW channel
  //////////////////////////////////////////////////

  assign mst_aw_o       = cut ? '0 : slv_aw_i;
  // Hold keeps an offered address valid until taken
  assign mst_aw_valid_o = hold | (pass & slv_aw_valid_i);
  assign slv_aw_ready_o = pass & mst_aw_ready_i;

  //////////////////////////////////////////////////
  // W channel
  //////////////////////////////////////////////////

  // No open data burst and no AW going out right now
  assign w_block = w_empty & ~issue;

  assign mst_w_o       = w_block ? '0 : slv_w_i;
  assign mst_w_valid_o = ~w_block & slv_w_valid_i;
  assign slv_w_ready_o = ~w_block & mst_w_ready_i;

  //////////////////////////////////////////////////
  // B channel
  //////////////////////////////////////////////////

  assign in_iso = (state == axi_iso_pkg::st_isolate);

  // Responses flow in every state except Isolate
  assign slv_b_o       = in_iso ? '0 : mst_b_i;
  assign slv_b_valid_o = ~in_iso & mst_b_valid_i;
  assign mst_b_ready_o = ~in_iso & slv_b_ready_i;

  assign isolated_o = in_iso;

endmodule

//--- hw/axi_iso_read_path.sv
`timescale 1ns/1ns

module axi_iso_read_path (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  isolate_i,
  // Slave port
  input  axi_iso_pkg::ar_chan_t slv_ar_i,
  input  logic                  slv_ar_valid_i,
  input  logic                  slv_r_ready_i,
  output logic                  slv_ar_ready_o,
  output axi_iso_pkg::r_chan_t  slv_r_o,
  output logic                  slv_r_valid_o,
  // Master port
  output axi_iso_pkg::ar_chan_t mst_ar_o,
  output logic                  mst_ar_valid_o,
  output logic                  mst_r_ready_o,
  input  logic                  mst_ar_ready_i,
  input  axi_iso_pkg::r_chan_t  mst_r_i,
  input  logic                  mst_r_valid_i,
  // Read side fully isolated
  output logic                  isolated_o
);

  logic                    pass;
  logic                    hold;
  logic                    cut;
  logic                    issue;
  axi_iso_pkg::iso_state_e state;

  logic                    ar_full;
  logic                    ar_empty;
  logic                    in_iso;

  //////////////////////////////////////////////////
  // Control and counter
  //////////////////////////////////////////////////

  axi_iso_chan_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .isolate_i   (isolate_i),
    .slv_valid_i (slv_ar_valid_i),
    .mst_ready_i (mst_ar_ready_i),
    .full_i      (ar_full),
    .empty_i     (ar_empty),
    .pass_o      (pass),
    .hold_o      (hold),
    .cut_o       (cut),
    .issue_o     (issue),
    .state_o     (state)
  );

  // Reads open from AR issue to the last R beat
  axi_iso_pending_cnt u_read_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .inc_i   (issue),
    .dec_i   (mst_r_valid_i & mst_r_ready_o & mst_r_i.last),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

  //////////////////////////////////////////////////
  // AR channel
  //////////////////////////////////////////////////

  assign mst_ar_o       = cut ? '0 : slv_ar_i;
  // Valid stays up in Hold whatever the slave port does
  assign mst_ar_valid_o = hold | (pass & slv_ar_valid_i);
  assign slv_ar_ready_o = pass & mst_ar_ready_i;

  //////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////

  assign in_iso = (state == axi_iso_pkg::st_isolate);

  // Read data still drains in Drain
  assign slv_r_o       = in_iso ? '0 : mst_r_i;
  assign slv_r_valid_o = ~in_iso & mst_r_valid_i;
  assign mst_r_ready_o = ~in_iso & slv_r_ready_i;

  assign isolated_o = in_iso;

endmodule

//--- hw/axi_iso_top.sv
`timescale 1ns/1ns

module axi_iso_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   isolate_i,
  input  axi_iso_pkg::axi_req_t  slv_req_i,
  output axi_iso_pkg::axi_resp_t slv_resp_o,
  output axi_iso_pkg::axi_req_t  mst_req_o,
  input  axi_iso_pkg::axi_resp_t mst_resp_i,
  output logic                   isolated_o
);

  // Master-side request fields from the two paths
  axi_iso_pkg::aw_chan_t mst_aw;
  logic                  mst_aw_valid;
  axi_iso_pkg::w_chan_t  mst_w;
  logic                  mst_w_valid;
  logic                  mst_b_ready;
  axi_iso_pkg::ar_chan_t mst_ar;
  logic                  mst_ar_valid;
  logic                  mst_r_ready;

  // Slave-side response fields from the two paths
  logic                  slv_aw_ready;
  logic                  slv_w_ready;
  axi_iso_pkg::b_chan_t  slv_b;
  logic                  slv_b_valid;
  logic                  slv_ar_ready;
  axi_iso_pkg::r_chan_t  slv_r;
  logic                  slv_r_valid;

  logic                  wr_isolated;
  logic                  rd_isolated;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  axi_iso_write_path u_write (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .isolate_i      (isolate_i),
    .slv_aw_i       (slv_req_i.aw),
    .slv_aw_valid_i (slv_req_i.aw_valid),
    .slv_w_i        (slv_req_i.w),
    .slv_w_valid_i  (slv_req_i.w_valid),
    .slv_b_ready_i  (slv_req_i.b_ready),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_b_ready_o  (mst_b_ready),
    .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_w_ready_i  (mst_resp_i.w_ready),
    .mst_b_i        (mst_resp_i.b),
    .mst_b_valid_i  (mst_resp_i.b_valid),
    .isolated_o     (wr_isolated)
  );

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  axi_iso_read_path u_read (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .isolate_i      (isolate_i),
    .slv_ar_i       (slv_req_i.ar),
    .slv_ar_valid_i (slv_req_i.ar_valid),
    .slv_r_ready_i  (slv_req_i.r_ready),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_r_ready_o  (mst_r_ready),
    .mst_ar_ready_i (mst_resp_i.ar_ready),
    .mst_r_i        (mst_resp_i.r),
    .mst_r_valid_i  (mst_resp_i.r_valid),
    .isolated_o     (rd_isolated)
  );

  //////////////////////////////////////////////////
  // Merge into the port bundles
  //////////////////////////////////////////////////

  always_comb begin
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = mst_w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    mst_req_o.ar       = mst_ar;
    mst_req_o.ar_valid = mst_ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  always_comb begin
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.ar_ready = slv_ar_ready;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

  // Isolated only when both sides have settled
  assign isolated_o = wr_isolated & rd_isolated;

endmodule

//--- test/axi_iso_props.sv
`timescale 1ns/1ns
`include "axi_iso_defines.svh"

module axi_iso_props (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   isolate_i,
  input axi_iso_pkg::axi_req_t  slv_req_i,
  input axi_iso_pkg::axi_resp_t slv_resp_i,
  input axi_iso_pkg::axi_req_t  mst_req_i,
  input axi_iso_pkg::axi_resp_t mst_resp_i,
  input logic                   isolated_i
);

  logic slv_aw_hs;
  logic slv_w_hs;
  logic slv_ar_hs;
  logic mst_aw_hs;
  logic mst_b_hs;
  logic mst_r_hs;
  logic mst_w_last_hs;
  logic mst_r_last_hs;

  // Master AW offered last cycle and not yet taken
  logic mst_aw_wait_q;
  // First cycle of a new address at the master port
  logic mst_aw_issue;

  // Open bursts seen at the master port
  int wr_open;
  int wd_open;
  int rd_open;

  // Number of failed assertions
  int fail_cnt = 0;

  assign slv_aw_hs     = slv_req_i.aw_valid & slv_resp_i.aw_ready;
  assign slv_w_hs      = slv_req_i.w_valid & slv_resp_i.w_ready;
  assign slv_ar_hs     = slv_req_i.ar_valid & slv_resp_i.ar_ready;
  assign mst_aw_hs     = mst_req_i.aw_valid & mst_resp_i.aw_ready;
  assign mst_b_hs      = mst_resp_i.b_valid & mst_req_i.b_ready;
  assign mst_r_hs      = mst_resp_i.r_valid & mst_req_i.r_ready;
  assign mst_w_last_hs = mst_req_i.w_valid & mst_resp_i.w_ready & mst_req_i.w.last;
  assign mst_r_last_hs = mst_r_hs & mst_resp_i.r.last;
  assign mst_aw_issue  = mst_req_i.aw_valid & ~mst_aw_wait_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mst_aw_wait_q <= 1'b0;
      wr_open       <= 0;
      wd_open       <= 0;
      rd_open       <= 0;
    end else begin
      mst_aw_wait_q <= mst_req_i.aw_valid & ~mst_resp_i.aw_ready;
      wr_open <= wr_open + int'(mst_aw_hs) - int'(mst_b_hs);
      // Data bursts open as soon as the address is offered
      wd_open <= wd_open + int'(mst_aw_issue) - int'(mst_w_last_hs);
      rd_open <= rd_open + int'(mst_req_i.ar_valid & mst_resp_i.ar_ready) - int'(mst_r_last_hs);
    end
  end

  //////////////////////////////////////////////////
  // Pass-through
  //////////////////////////////////////////////////

  a_aw_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_aw_hs |-> mst_aw_hs && (mst_req_i.aw == slv_req_i.aw))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("AW handshake not passed to master");
    end

  a_w_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_w_hs |-> mst_req_i.w_valid && mst_resp_i.w_ready && (mst_req_i.w == slv_req_i.w))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("W handshake not passed to master");
    end

  a_ar_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_ar_hs |-> mst_req_i.ar_valid && mst_resp_i.ar_ready && (mst_req_i.ar == slv_req_i.ar))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("AR handshake not passed to master");
    end

  a_b_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_b_hs |-> slv_resp_i.b_valid && slv_req_i.b_ready && (slv_resp_i.b == mst_resp_i.b))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("B handshake not passed to slave");
    end

  a_r_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_r_hs |-> slv_resp_i.r_valid && slv_req_i.r_ready && (slv_resp_i.r == mst_resp_i.r))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("R handshake not passed to slave");
    end

  //////////////////////////////////////////////////
  // Limits and W gating
  //////////////////////////////////////////////////

  a_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_open <= `AXI_ISO_NUM_PENDING && rd_open <= `AXI_ISO_NUM_PENDING)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Open transactions above limit");
    end

  a_w_gate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i.w_valid |-> (wd_open != 0) || mst_aw_issue)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("W valid without an open write burst");
    end

  //////////////////////////////////////////////////
  // Isolation
  //////////////////////////////////////////////////

  a_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(isolated_i) |-> wr_open == 0 && rd_open == 0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Isolated with transactions open");
    end

  // Nothing towards the master, no address accepted from the slave
  a_silent: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated_i |-> !(mst_req_i.aw_valid | mst_req_i.w_valid | mst_req_i.b_ready |
                     mst_req_i.ar_valid | mst_req_i.r_ready |
                     slv_resp_i.aw_ready | slv_resp_i.ar_ready))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Port active while isolated");
    end

  a_iso_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(isolate_i) && wr_open == 0 && rd_open == 0 &&
    !mst_req_i.aw_valid && !mst_req_i.ar_valid |-> ##2 isolated_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Idle bus not isolated after two cycles");
    end

  a_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(isolate_i) && isolated_i |-> ##1 (!isolated_i &&
      slv_resp_i.aw_ready == mst_resp_i.aw_ready &&
      slv_resp_i.ar_ready == mst_resp_i.ar_ready))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Ports not reconnected after release");
    end

endmodule

bind axi_iso_top axi_iso_props u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .isolate_i  (isolate_i),
  .slv_req_i  (slv_req_i),
  .slv_resp_i (slv_resp_o),
  .mst_req_i  (mst_req_o),
  .mst_resp_i (mst_resp_i),
  .isolated_i (isolated_o)
);

//--- test/axi_iso_tb.sv
`timescale 1ns/1ns
`include "axi_iso_defines.svh"

module axi_iso_tb;

  // Cycle budget of each test phase
  localparam int PHASE_CYC    = 1500;
  localparam int DRAIN_MAX    = 1000;
  // Two traffic phases and two drains, with a wide margin
  localparam int WATCHDOG_CYC = 4 * (2 * PHASE_CYC + 2 * DRAIN_MAX);

  logic clk;
  logic rst_n;
  logic isolate;
  logic isolated;

  axi_iso_pkg::axi_req_t  slv_req;
  axi_iso_pkg::axi_resp_t slv_resp;
  axi_iso_pkg::axi_req_t  mst_req;
  axi_iso_pkg::axi_resp_t mst_resp;

  // Master model, no new addresses while quiet
  logic                  quiet;
  axi_iso_pkg::len_t     aw_len;
  axi_iso_pkg::len_t     w_len_q[$];
  int                    w_beat;
  int                    wr_issued;
  int                    wr_done;
  int                    rd_issued;
  int                    rd_done;

  // Slave model
  axi_iso_pkg::id_t      b_wait_q[$];
  int                    w_last_cnt;
  axi_iso_pkg::id_t      b_q[$];
  axi_iso_pkg::ar_chan_t r_q[$];
  int                    r_beat;

  int                    err_cnt;
  int                    wr_mark;
  int                    rd_mark;

  axi_iso_top dut0 (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .isolate_i  (isolate),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .isolated_o (isolated)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random master on the slave port
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (slv_req.aw_valid && slv_resp.aw_ready) begin
        wr_issued <= wr_issued + 1;
      end
      // Valid only drops after a handshake
      if (!slv_req.aw_valid || slv_resp.aw_ready) begin
        if (!quiet && ($urandom % 4 == 0)) begin
          // Each new AW queues its W burst at once
          aw_len = axi_iso_pkg::len_t'($urandom % 4);
          w_len_q.push_back(aw_len);
          slv_req.aw_valid <= 1'b1;
        end else begin
          slv_req.aw_valid <= 1'b0;
        end
        slv_req.aw.id    <= axi_iso_pkg::id_t'($urandom);
        slv_req.aw.addr  <= axi_iso_pkg::addr_t'($urandom);
        slv_req.aw.len   <= aw_len;
      end
      if (slv_req.w_valid && slv_resp.w_ready) begin
        if (slv_req.w.last) begin
          void'(w_len_q.pop_front());
          w_beat = 0;
        end else begin
          w_beat = w_beat + 1;
        end
      end
      // W beats may run ahead of their AW
      if (!slv_req.w_valid || slv_resp.w_ready) begin
        slv_req.w_valid <= (w_len_q.size() > 0) && ($urandom % 3 != 0);
        slv_req.w.data  <= axi_iso_pkg::data_t'($urandom);
        slv_req.w.strb  <= '1;
        slv_req.w.last  <= (w_len_q.size() > 0) && (w_beat == int'(w_len_q[0]));
      end
      if (slv_req.b_ready && slv_resp.b_valid) begin
        wr_done <= wr_done + 1;
      end
      slv_req.b_ready <= ($urandom % 4 != 0);
      if (slv_req.ar_valid && slv_resp.ar_ready) begin
        rd_issued <= rd_issued + 1;
      end
      if (!slv_req.ar_valid || slv_resp.ar_ready) begin
        slv_req.ar_valid <= !quiet && ($urandom % 4 == 0);
        slv_req.ar.id    <= axi_iso_pkg::id_t'($urandom);
        slv_req.ar.addr  <= axi_iso_pkg::addr_t'($urandom);
        slv_req.ar.len   <= axi_iso_pkg::len_t'($urandom % 4);
      end
      if (slv_req.r_ready && slv_resp.r_valid && slv_resp.r.last) begin
        rd_done <= rd_done + 1;
      end
      slv_req.r_ready <= ($urandom % 4 != 0);
    end
  end

  //////////////////////////////////////////////////
  // Random slave on the master port
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        b_wait_q.push_back(mst_req.aw.id);
      end
      if (mst_req.w_valid && mst_resp.w_ready && mst_req.w.last) begin
        w_last_cnt = w_last_cnt + 1;
      end
      // B waits for both the address and the last data beat
      if (b_wait_q.size() > 0 && w_last_cnt > 0) begin
        b_q.push_back(b_wait_q.pop_front());
        w_last_cnt = w_last_cnt - 1;
      end
      mst_resp.aw_ready <= ($urandom % 3 != 0);
      mst_resp.w_ready  <= ($urandom % 3 != 0);
      if (mst_resp.b_valid && mst_req.b_ready) begin
        void'(b_q.pop_front());
      end
      if (!mst_resp.b_valid || mst_req.b_ready) begin
        mst_resp.b_valid <= (b_q.size() > 0) && ($urandom % 2 == 0);
        mst_resp.b.id    <= (b_q.size() > 0) ? b_q[0] : '0;
        mst_resp.b.resp  <= '0;
      end
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        r_q.push_back(mst_req.ar);
      end
      mst_resp.ar_ready <= ($urandom % 3 != 0);
      if (mst_resp.r_valid && mst_req.r_ready) begin
        if (mst_resp.r.last) begin
          void'(r_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat = r_beat + 1;
        end
      end
      // Read bursts come back in order
      if (!mst_resp.r_valid || mst_req.r_ready) begin
        mst_resp.r_valid <= (r_q.size() > 0) && ($urandom % 2 == 0);
        mst_resp.r.id    <= (r_q.size() > 0) ? r_q[0].id : '0;
        mst_resp.r.data  <= axi_iso_pkg::data_t'($urandom);
        mst_resp.r.resp  <= '0;
        mst_resp.r.last  <= (r_q.size() > 0) && (r_beat == int'(r_q[0].len));
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_isolated(input logic exp, input string what);
    if (isolated !== exp) begin
      $display("FAIL %0t ns: isolated_o is %b, expected %b %s", $time, isolated, exp, what);
      err_cnt++;
    end
  endtask

  task automatic check_progress(input int wr, input int rd, input string what);
    if (wr <= 0 || rd <= 0) begin
      $display("FAIL %0t ns: %s completed %0d writes and %0d reads", $time, what, wr, rd);
      err_cnt++;
    end
  endtask

  task automatic wait_isolated();
    int n;
    n = 0;
    while (!isolated && n < DRAIN_MAX) begin
      @(posedge clk);
      n++;
    end
    if (!isolated) begin
      $display("ERROR: isolation was not reached within %0d cycles", DRAIN_MAX);
      err_cnt++;
    end
  endtask

  // Model state is read away from the active edge
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (n < DRAIN_MAX && (slv_req.aw_valid || slv_req.ar_valid || w_len_q.size() > 0 ||
           wr_issued != wr_done || rd_issued != rd_done)) begin
      @(negedge clk);
      n++;
    end
    if (n >= DRAIN_MAX) begin
      $display("ERROR: open traffic did not drain within %0d cycles", DRAIN_MAX);
      err_cnt++;
    end
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h80c3));
    err_cnt    = 0;
    wr_issued  = 0;
    wr_done    = 0;
    rd_issued  = 0;
    rd_done    = 0;
    w_beat     = 0;
    r_beat     = 0;
    w_last_cnt = 0;
    quiet      = 1'b0;
    rst_n      = 1'b0;
    isolate    = 1'b0;
    slv_req    = '0;
    mst_resp   = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Isolated out of reset, Normal one cycle later
    @(posedge clk);
    check_isolated(1'b1, "after reset");
    @(posedge clk);
    check_isolated(1'b0, "one cycle after reset");

    // Free traffic
    wr_mark = wr_done;
    rd_mark = rd_done;
    repeat (PHASE_CYC) @(posedge clk);
    check_isolated(1'b0, "during free traffic");
    check_progress(wr_done - wr_mark, rd_done - rd_mark, "phase 1");

    // Isolate with bursts still open
    isolate <= 1'b1;
    wait_isolated();
    repeat (PHASE_CYC / 5) @(posedge clk);
    check_isolated(1'b1, "while isolate_i is held");

    // Release and run more traffic
    isolate <= 1'b0;
    repeat (2) @(posedge clk);
    check_isolated(1'b0, "after release");
    wr_mark = wr_done;
    rd_mark = rd_done;
    repeat (PHASE_CYC) @(posedge clk);
    check_progress(wr_done - wr_mark, rd_done - rd_mark, "phase 3");

    // Isolate an idle bus, fixed two-cycle latency
    quiet <= 1'b1;
    wait_idle();
    isolate <= 1'b1;
    repeat (3) @(posedge clk);
    check_isolated(1'b1, "two cycles after isolating an idle bus");

    $display("Errors: testbench %0d, assertions %0d", err_cnt, dut0.u_props.fail_cnt);
    if (err_cnt == 0 && dut0.u_props.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+hw
hw/axi_iso_pkg.sv
hw/axi_iso_pending_cnt.sv
hw/axi_iso_chan_ctrl.sv
hw/axi_iso_write_path.sv
hw/axi_iso_read_path.sv
hw/axi_iso_top.sv
test/axi_iso_props.sv
test/axi_iso_tb.sv
